// ==== umi_mem_node.f ====
common/umi_pkg.sv
common/mem_pkg.sv
logic/umi_arbiter.sv
endpoint/umi_endpoint.sv
logic/merge_memory.sv
logic/umi_mem_node.sv
testbench/tb_umi_mem_node.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the umi memory node testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
   -f umi_mem_node.f \
   --top-module tb_umi_mem_node \
   -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

./obj_dir/Vtb_umi_mem_node > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
   echo "simulation reported failure"
   exit 1
fi

exit 0

// ==== testbench/tb_umi_mem_node.sv ====
// UMI memory node testbench
`timescale 1ns/1ps

module tb_umi_mem_node;

   localparam int clk_period = 20;
   localparam int n_full     = 6;     // full write then read pairs
   localparam int n_merge    = 6;     // words that get sub-word writes
   localparam int n_prio     = 4;     // same-cycle write and read pairs
   localparam int n_trans    = 2*n_full + 7*n_merge + 2*n_prio + 6;
   localparam int margin     = 100;   // cycles for reset and drain

   logic                   clk = 1'b0;
   logic                   nreset;
   logic                   umi0_in_valid;
   umi_pkg::umi_packet_t   umi0_in_packet;
   logic                   umi0_in_ready;
   logic                   umi1_in_valid;
   umi_pkg::umi_packet_t   umi1_in_packet;
   logic                   umi1_in_ready;
   logic                   umi0_out_valid;
   umi_pkg::umi_packet_t   umi0_out_packet;
   logic                   umi0_out_ready;

   logic [63:0]            model [256];     // word view of the memory
   umi_pkg::umi_packet_t   exp_q [$];       // responses still owed
   umi_pkg::umi_packet_t   held_pkt;        // output packet one edge ago
   logic [31:0]            known [$];       // addresses of written words
   logic                   wr_partial;
   string                  test_name;
   int unsigned            data_errors  = 0;
   int unsigned            proto_errors = 0;
   int unsigned            reads_seen   = 0;
   int unsigned            resp_seen    = 0;

   always #(clk_period/2) clk = ~clk;

   umi_mem_node u_umi_mem_node
   (
      .clk             (clk),
      .nreset          (nreset),
      .umi0_in_valid   (umi0_in_valid),
      .umi0_in_packet  (umi0_in_packet),
      .umi0_in_ready   (umi0_in_ready),
      .umi1_in_valid   (umi1_in_valid),
      .umi1_in_packet  (umi1_in_packet),
      .umi1_in_ready   (umi1_in_ready),
      .umi0_out_valid  (umi0_out_valid),
      .umi0_out_packet (umi0_out_packet),
      .umi0_out_ready  (umi0_out_ready)
   );

   //##########################################################
   // reference model
   //##########################################################

   // 2**size bytes from the low end of data, cut off at byte 7
   function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [2:0] off,
                                               input logic [1:0] size, input logic [63:0] data);
      logic [63:0] w;
      int          nbytes;
      w      = old;
      nbytes = 1 << size;
      for (int i = 0; i < nbytes; i++)
      begin
         if (int'(off) + i < 8)
            w[8*(int'(off) + i) +: 8] = data[8*i +: 8];
      end
      return w;
   endfunction

   function automatic logic [31:0] rand_word_addr();
      logic [31:0] a;
      a      = $urandom;
      a[2:0] = 3'b000;   // word aligned, upper bits wrap in the DUT
      return a;
   endfunction

   // transfers happen at the next edge, signals are settled here
   always @(negedge clk)
   begin
      umi_pkg::umi_packet_t exp;
      if (nreset)
      begin
         if (umi0_in_valid && umi0_in_ready)
            model[umi0_in_packet.dstaddr[10:3]] = merge_bytes(model[umi0_in_packet.dstaddr[10:3]],
               umi0_in_packet.dstaddr[2:0], umi0_in_packet.size, umi0_in_packet.data);
         if (umi1_in_valid && umi1_in_ready)
         begin
            exp         = '0;
            exp.cmd     = umi_pkg::cmd_resp_read;
            exp.size    = umi1_in_packet.size;
            exp.options = umi1_in_packet.options;
            exp.dstaddr = umi1_in_packet.srcaddr;       // back to requester
            exp.data    = model[umi1_in_packet.dstaddr[10:3]];
            exp_q.push_back(exp);
            reads_seen++;
         end
         if (umi0_out_valid && umi0_out_ready)
         begin
            resp_seen++;
            if (exp_q.size() == 0)
            begin
               data_errors++;
               $display("ERROR: %s response arrived with no read outstanding", test_name);
            end
            else
            begin
               exp = exp_q.pop_front();   // in order, oldest first
               assert (umi0_out_packet == exp)
               else
               begin
                  data_errors++;
                  $display("FAIL %s: expected %h, actual %h", test_name, exp, umi0_out_packet);
               end
            end
         end
      end
   end

   //##########################################################
   // protocol assertions
   //##########################################################

   always @(posedge clk) held_pkt <= umi0_out_packet;
   assign wr_partial = !(umi0_in_packet.size == 2'd3 && umi0_in_packet.dstaddr[2:0] == 3'd0);

   a_reset: assert property (@(posedge clk)
      !nreset |-> !umi0_out_valid && !umi0_in_ready && !umi1_in_ready)
   else
   begin
      proto_errors++;
      $display("FAIL %s: in reset expected 000, actual %b%b%b", test_name,
               $sampled(umi0_out_valid), $sampled(umi0_in_ready), $sampled(umi1_in_ready));
   end

   // stalled response holds still
   a_hold: assert property (@(posedge clk) disable iff (!nreset)
      umi0_out_valid && !umi0_out_ready |=> umi0_out_valid && umi0_out_packet == held_pkt)
   else
   begin
      proto_errors++;
      $display("FAIL %s: stalled output expected %h, actual %h", test_name,
               $sampled(held_pkt), $sampled(umi0_out_packet));
   end

   a_stall_read: assert property (@(posedge clk) disable iff (!nreset)
      umi0_out_valid && !umi0_out_ready |-> !umi1_in_ready)
   else
   begin
      proto_errors++;
      $display("FAIL %s: umi1_in ready under stall expected 0, actual 1", test_name);
   end

   a_priority: assert property (@(posedge clk) disable iff (!nreset)
      umi0_in_valid |-> !umi1_in_ready)
   else
   begin
      proto_errors++;
      $display("FAIL %s: umi1_in ready beside channel 0 expected 0, actual 1", test_name);
   end

   a_resp_next: assert property (@(posedge clk) disable iff (!nreset)
      umi1_in_valid && umi1_in_ready |=> umi0_out_valid)
   else
   begin
      proto_errors++;
      $display("FAIL %s: umi0_out valid after read expected 1, actual 0", test_name);
   end

   // one merge cycle, nobody gets in
   a_merge: assert property (@(posedge clk) disable iff (!nreset)
      umi0_in_valid && umi0_in_ready && wr_partial |=> !umi0_in_ready && !umi1_in_ready)
   else
   begin
      proto_errors++;
      $display("FAIL %s: readys in merge cycle expected 00, actual %b%b", test_name,
               $sampled(umi0_in_ready), $sampled(umi1_in_ready));
   end

   //##########################################################
   // stimulus
   //##########################################################

   task automatic send_write(input logic [31:0] addr, input logic [1:0] size,
                             input logic [63:0] data);
      umi_pkg::umi_packet_t p;
      p         = '0;
      p.cmd     = umi_pkg::cmd_write;
      p.size    = size;
      p.options = 8'h5a;
      p.dstaddr = addr;
      p.data    = data;
      @(posedge clk);
      #2;
      umi0_in_valid  = 1'b1;
      umi0_in_packet = p;
      @(negedge clk);
      while (!umi0_in_ready) @(negedge clk);   // held until taken
      @(posedge clk);
      #2;
      umi0_in_valid  = 1'b0;
      umi0_in_packet = '0;
   endtask

   task automatic send_read(input logic [31:0] addr);
      umi_pkg::umi_packet_t p;
      logic [31:0]          r;
      r         = $urandom;
      p         = '0;
      p.cmd     = umi_pkg::cmd_read;
      p.size    = r[1:0];      // echoed only
      p.options = r[15:8];
      p.dstaddr = addr;
      p.srcaddr = $urandom;
      @(posedge clk);
      #2;
      umi1_in_valid  = 1'b1;
      umi1_in_packet = p;
      @(negedge clk);
      while (!umi1_in_ready) @(negedge clk);
      @(posedge clk);
      #2;
      umi1_in_valid  = 1'b0;
      umi1_in_packet = '0;
   endtask

   initial
   begin
      logic [31:0] base;
      logic [31:0] r;
      void'($urandom(32'hd79));
      test_name      = "reset";
      nreset         = 1'b0;
      umi0_in_valid  = 1'b0;
      umi0_in_packet = '0;
      umi1_in_valid  = 1'b0;
      umi1_in_packet = '0;
      umi0_out_ready = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      nreset = 1'b1;
      @(negedge clk);
      assert (!umi0_out_valid && !umi0_in_ready && !umi1_in_ready)
      else
      begin
         proto_errors++;
         $display("FAIL reset: after release expected 000, actual %b%b%b",
                  umi0_out_valid, umi0_in_ready, umi1_in_ready);
      end

      test_name = "full_write_read";
      for (int i = 0; i < n_full; i++)
      begin
         base = rand_word_addr();
         send_write(base, 2'd3, {$urandom, $urandom});
         send_read(base);
         known.push_back(base);
      end

      // read sits beside each write, so it lands after the merge
      test_name = "sub_word_merge";
      for (int w = 0; w < n_merge; w++)
      begin
         base = rand_word_addr();
         send_write(base, 2'd3, {$urandom, $urandom});
         for (int s = 0; s < 3; s++)
         begin
            r = $urandom;
            fork
               send_write({base[31:3], r[2:0]}, 2'(s), {$urandom, $urandom});
               send_read(base);
            join
         end
         known.push_back(base);
      end

      test_name = "priority";
      for (int i = 0; i < n_prio; i++)
      begin
         fork
            send_write(rand_word_addr(), 2'd3, {$urandom, $urandom});
            send_read(known[i]);
         join
      end

      test_name = "back_pressure";
      @(posedge clk);
      #2;
      umi0_out_ready = 1'b0;
      fork
         begin
            for (int i = 0; i < 4; i++)
               send_read(known[i + 2]);
         end
         begin
            send_write(rand_word_addr(), 2'd3, {$urandom, $urandom});   // posted, not blocked
            send_write(rand_word_addr() | 32'd5, 2'd1, {$urandom, $urandom});
         end
         begin
            repeat (12) @(posedge clk);
            #2;
            umi0_out_ready = 1'b1;
         end
      join

      test_name = "drain";
      while (exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      if (resp_seen != reads_seen)
      begin
         data_errors++;
         $display("FAIL %s: expected %0d responses, actual %0d", test_name, reads_seen, resp_seen);
      end
      $display("errors: %0d data, %0d protocol; reads %0d, responses %0d",
               data_errors, proto_errors, reads_seen, resp_seen);
      if (data_errors + proto_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // roughly 40 cycles per transaction is far more than needed
   initial
   begin
      #(clk_period * (n_trans * 40 + margin));
      $display("ERROR: watchdog expired, the run did not complete in time");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== logic/umi_mem_node.sv ====
// UMI memory node top
`timescale 1ns/1ps

module umi_mem_node
(
   input  logic                  clk,
   input  logic                  nreset,
   // writes in
   input  logic                  umi0_in_valid,
   input  umi_pkg::umi_packet_t  umi0_in_packet,
   output logic                  umi0_in_ready,
   // reads in
   input  logic                  umi1_in_valid,
   input  umi_pkg::umi_packet_t  umi1_in_packet,
   output logic                  umi1_in_ready,
   // read responses out
   output logic                  umi0_out_valid,
   output umi_pkg::umi_packet_t  umi0_out_packet,
   input  logic                  umi0_out_ready
);

   mem_pkg::mem_req_t                mem_req;      // endpoint to memory
   logic [umi_pkg::data_w-1:0]       mem_rddata;   // word read back
   logic                             mem_ready;    // low during merge

   //##########################################################
   // endpoint
   //##########################################################

   umi_endpoint u_umi_endpoint
   (
      .clk             (clk),
      .nreset          (nreset),
      .umi0_in_valid   (umi0_in_valid),
      .umi0_in_packet  (umi0_in_packet),
      .umi0_in_ready   (umi0_in_ready),
      .umi1_in_valid   (umi1_in_valid),
      .umi1_in_packet  (umi1_in_packet),
      .umi1_in_ready   (umi1_in_ready),
      .umi0_out_valid  (umi0_out_valid),
      .umi0_out_packet (umi0_out_packet),
      .umi0_out_ready  (umi0_out_ready),
      .mem_req         (mem_req),
      .mem_rddata      (mem_rddata),
      .mem_ready       (mem_ready)
   );

   // local memory behind it
   merge_memory u_merge_memory
   (
      .clk        (clk),
      .nreset     (nreset),
      .mem_req    (mem_req),
      .mem_rddata (mem_rddata),
      .mem_ready  (mem_ready)
   );

endmodule

// ==== logic/merge_memory.sv ====
// Word memory with byte merge
`timescale 1ns/1ps

module merge_memory
(
   input  logic                           clk,
   input  logic                           nreset,
   input  mem_pkg::mem_req_t              mem_req,
   output logic [mem_pkg::word_w-1:0]     mem_rddata,
   output logic                           mem_ready
);

   logic [mem_pkg::word_w-1:0]       mem_array [mem_pkg::mem_words];

   logic                             full_wr;      // direct store
   logic                             part_wr;      // needs merge cycle
   logic [4:0]                       span_end;     // first byte past write
   logic [mem_pkg::word_bytes-1:0]   wr_mask;      // lanes being written
   logic [mem_pkg::word_w-1:0]       wr_shifted;   // payload at its lanes

   // commit register for the merge cycle
   logic                             pend_valid;
   logic [mem_pkg::word_idx_w-1:0]   pend_index;
   logic [mem_pkg::word_bytes-1:0]   pend_mask;
   logic [mem_pkg::word_w-1:0]       pend_data;
   logic [mem_pkg::word_w-1:0]       merged;

   //##########################################################
   // write classification
   //##########################################################

   assign mem_ready = ~pend_valid;   // busy only while merging

   assign full_wr = mem_req.write & mem_ready &
                    (mem_req.size == mem_pkg::size_full) &
                    (mem_req.byte_off == '0);
   assign part_wr = mem_req.write & mem_ready & ~full_wr;

   // 2**size bytes from byte_off, lanes past 7 just fall off
   assign span_end   = {2'b00, mem_req.byte_off} + (5'd1 << mem_req.size);
   assign wr_shifted = mem_req.wrdata << {mem_req.byte_off, 3'b000};

   always_comb
   begin
      for (int b = 0; b < mem_pkg::word_bytes; b++)
      begin
         wr_mask[b] = (5'(b) >= {2'b00, mem_req.byte_off}) && (5'(b) < span_end);
      end
   end

   //##########################################################
   // merge path
   //##########################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pend_valid <= 1'b0;
      end
      else
      begin
         pend_valid <= part_wr;   // self clears, part_wr needs mem_ready
      end
   end

   always_ff @(posedge clk)
   begin
      if (part_wr)
      begin
         pend_index <= mem_req.index;
         pend_mask  <= wr_mask;
         pend_data  <= wr_shifted;
      end
   end

   // old word with the new lanes dropped in
   always_comb
   begin
      for (int b = 0; b < mem_pkg::word_bytes; b++)
      begin
         merged[8*b +: 8] = pend_mask[b] ? pend_data[8*b +: 8] :
                                           mem_array[pend_index][8*b +: 8];
      end
   end

   //##########################################################
   // storage
   //##########################################################

   always_ff @(posedge clk)
   begin
      if (pend_valid)
      begin
         mem_array[pend_index] <= merged;           // second cycle of rmw
      end
      else if (full_wr)
      begin
         mem_array[mem_req.index] <= mem_req.wrdata;
      end
   end

   // same cycle read
   assign mem_rddata = mem_req.read ? mem_array[mem_req.index] : '0;

endmodule

// ==== endpoint/umi_endpoint.sv ====
// UMI memory endpoint
`timescale 1ns/1ps

module umi_endpoint
(
   input  logic                           clk,
   input  logic                           nreset,
   // write channel
   input  logic                           umi0_in_valid,
   input  umi_pkg::umi_packet_t           umi0_in_packet,
   output logic                           umi0_in_ready,
   // read channel
   input  logic                           umi1_in_valid,
   input  umi_pkg::umi_packet_t           umi1_in_packet,
   output logic                           umi1_in_ready,
   // read responses
   output logic                           umi0_out_valid,
   output umi_pkg::umi_packet_t           umi0_out_packet,
   input  logic                           umi0_out_ready,
   // local memory
   output mem_pkg::mem_req_t              mem_req,
   input  logic [umi_pkg::data_w-1:0]     mem_rddata,
   input  logic                           mem_ready
);

   logic                   sel_valid;    // arbiter has a winner
   umi_pkg::umi_packet_t   sel_packet;   // winning packet
   logic                   accept;       // winner taken this cycle
   logic                   is_read;
   logic                   is_write;
   logic                   slot_free;    // response reg can take a read
   logic                   read_fire;    // read consumed by memory
   umi_pkg::umi_packet_t   resp_q;       // registered response

   //##########################################################
   // input arbiter
   //##########################################################

   umi_arbiter u_umi_arbiter
   (
      .in_valid   ({umi1_in_valid, umi0_in_valid}),
      .in_packet  ({umi1_in_packet, umi0_in_packet}),
      .in_ready   ({umi1_in_ready, umi0_in_ready}),
      .accept     (accept),
      .sel_valid  (sel_valid),
      .sel_packet (sel_packet)
   );

   assign is_read  = (sel_packet.cmd == umi_pkg::cmd_read);
   assign is_write = (sel_packet.cmd == umi_pkg::cmd_write);

   // one response in flight at most
   assign slot_free = ~umi0_out_valid | umi0_out_ready;   // empty or draining

   // writes go as soon as memory is ready, reads also need the slot
   // other commands get accepted and dropped so the channel never hangs
   assign accept    = sel_valid & mem_ready & (~is_read | slot_free);
   assign read_fire = accept & is_read;

   //##########################################################
   // decode to memory request
   //##########################################################

   always_comb
   begin
      mem_req.write    = accept & is_write;
      mem_req.read     = read_fire;
      // word index is dstaddr / 8, wrapping at memory depth
      mem_req.index    = sel_packet.dstaddr[mem_pkg::byte_off_w +: mem_pkg::word_idx_w];
      mem_req.byte_off = sel_packet.dstaddr[mem_pkg::byte_off_w-1:0];
      mem_req.size     = sel_packet.size;
      mem_req.wrdata   = sel_packet.data;   // low bytes hold the payload
   end

   //##########################################################
   // response valid
   //##########################################################

   // a new read can land while the old response drains, so set wins
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         umi0_out_valid <= 1'b0;
      end
      else if (read_fire)
      begin
         umi0_out_valid <= 1'b1;
      end
      else if (umi0_out_ready)
      begin
         umi0_out_valid <= 1'b0;   // handshake done
      end
   end

   //##########################################################
   // response packet
   //##########################################################

   always_ff @(posedge clk)
   begin
      if (read_fire)
      begin
         resp_q.cmd     <= umi_pkg::cmd_resp_read;
         resp_q.size    <= sel_packet.size;      // echoed
         resp_q.options <= sel_packet.options;   // echoed
         resp_q.dstaddr <= sel_packet.srcaddr;   // back to requester
         resp_q.srcaddr <= '0;
         resp_q.data    <= mem_rddata;           // whole word
         resp_q.pad     <= '0;
      end
   end

   // stays put while the receiver stalls
   assign umi0_out_packet = resp_q;

endmodule

// ==== logic/umi_arbiter.sv ====
// Fixed priority UMI arbiter
`timescale 1ns/1ps

module umi_arbiter
(
   input  logic [1:0]                  in_valid,     // per channel request
   input  umi_pkg::umi_packet_t [1:0]  in_packet,
   output logic [1:0]                  in_ready,     // per channel grant
   input  logic                        accept,       // endpoint takes sel
   output logic                        sel_valid,
   output umi_pkg::umi_packet_t        sel_packet
);

   logic [1:0] grant;      // one hot, lowest valid wins
   logic       sel_idx;    // channel feeding sel_packet

   //##########################################################
   // priority select
   //##########################################################

   // channel 0 always wins, channel 1 only when 0 is idle
   always_comb
   begin
      grant[0] = in_valid[0];
      grant[1] = in_valid[1] & ~in_valid[0];
   end

   assign sel_idx   = grant[1];       // 0 unless channel 1 won
   assign sel_valid = |in_valid;      // anyone asking

   // packet of the winner, no register in the path
   assign sel_packet = in_packet[sel_idx];

   //##########################################################
   // ready back to the senders
   //##########################################################

   // loser sees ready low, so it keeps holding its packet
   assign in_ready = grant & {2{accept}};

endmodule

// ==== common/mem_pkg.sv ====
// Local memory request format
package mem_pkg;

   //##########################################################
   // word geometry
   //##########################################################

   localparam int word_w     = 64;             // bits per word
   localparam int word_bytes = word_w / 8;     // byte lanes per word
   localparam int byte_off_w = 3;              // byte lane select
   localparam int mem_words  = 256;            // memory depth
   localparam int word_idx_w = 8;              // log2(mem_words)
   localparam int size_w     = 2;              // same coding as umi size

   localparam logic [size_w-1:0] size_full = 2'd3;   // 8 bytes

   //##########################################################
   // request from endpoint to memory
   //##########################################################

   // consumed whenever read or write is set and the memory is ready
   typedef struct packed
   {
      logic                    write;
      logic                    read;
      logic [word_idx_w-1:0]   index;      // word address
      logic [byte_off_w-1:0]   byte_off;   // first byte written
      logic [size_w-1:0]       size;       // 2**size bytes
      logic [word_w-1:0]       wrdata;     // low bytes carry the payload
   } mem_req_t;

endpackage

// ==== common/umi_pkg.sv ====
// UMI packet format
package umi_pkg;

   //##########################################################
   // field widths
   //##########################################################

   localparam int addr_w    = 32;   // dstaddr and srcaddr
   localparam int data_w    = 64;   // one full data word
   localparam int size_w    = 2;    // log2 of bytes in transfer
   localparam int options_w = 8;    // opaque, echoed in responses
   localparam int cmd_w     = 3;
   localparam int pad_w     = 6;    // rounds packet up to 147 bits

   //##########################################################
   // command encoding
   //##########################################################

   typedef enum logic [cmd_w-1:0]
   {
      cmd_read      = 3'b001,   // request, wants a response
      cmd_write     = 3'b010,   // posted, no ack
      cmd_resp_read = 3'b011    // read data going back
   } umi_cmd_e;

   //##########################################################
   // packet layout, first field is the msb end
   //##########################################################

   typedef struct packed
   {
      umi_cmd_e               cmd;
      logic [size_w-1:0]      size;      // 0..3 -> 1,2,4,8 bytes
      logic [options_w-1:0]   options;
      logic [addr_w-1:0]      dstaddr;   // where the packet goes
      logic [addr_w-1:0]      srcaddr;   // where a response goes
      logic [data_w-1:0]      data;      // write data or read data
      logic [pad_w-1:0]       pad;       // zero
   } umi_packet_t;

endpackage
